/* pickin_defs.svh */
`ifndef PICKIN_DEFS_SVH
`define PICKIN_DEFS_SVH

`define PICKIN_AUDIO_BITS 13
`define PICKIN_COLOR_BITS 3
`define PICKIN_SYNC_STAGES 2

// PS/2 set 2 scancodes. The four arrows arrive behind an E0 prefix.
`define PICKIN_KEY_UP     8'h75
`define PICKIN_KEY_DOWN   8'h72
`define PICKIN_KEY_LEFT   8'h6B
`define PICKIN_KEY_RIGHT  8'h74
`define PICKIN_KEY_CTRL   8'h14
`define PICKIN_KEY_ALT    8'h11
`define PICKIN_KEY_SPACE  8'h29
`define PICKIN_KEY_1      8'h16
`define PICKIN_KEY_2      8'h1E
`define PICKIN_KEY_5      8'h2E
`define PICKIN_KEY_6      8'h36
`define PICKIN_KEY_T      8'h2C
`define PICKIN_KEY_R      8'h2D
`define PICKIN_KEY_F      8'h2B
`define PICKIN_KEY_D      8'h23
`define PICKIN_KEY_G      8'h34
`define PICKIN_KEY_A      8'h1C
`define PICKIN_KEY_BREAK  8'hF0
`define PICKIN_KEY_EXT    8'hE0

`endif

/* pickin_pkg.sv */
package pickin_pkg;

	// Command codes sent by the configuration controller as the first byte of a frame.
	typedef enum logic [7:0] {
		CMD_BUTTONS = 8'h01, // Buttons in bits 1:0, switches in bits 3:2.
		CMD_JOY0    = 8'h02,
		CMD_JOY1    = 8'h03,
		CMD_KEY     = 8'h04, // One PS/2 scancode byte.
		CMD_STATUS  = 8'h1E  // Four bytes, least significant first.
	} spi_cmd_e;

	typedef struct packed {
		logic [24:0] spare;
		logic        reset_trigger;
		logic        blend;
		logic [1:0]  scanlines;
		logic        rotate_ctrl;
		logic        pad;
		logic        menu_reset;
	} status_fields_t;

	// The status word is filled bytewise as raw bits and read back by field.
	typedef union packed {
		logic [31:0]    raw;
		status_fields_t fields;
	} status_word_t;

endpackage

/* spi_cmd_rx.sv */
`include "pickin_defs.svh"

module spi_cmd_rx (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 spi_sck,
	input  logic                 spi_ss_io,
	input  logic                 spi_di,
	output logic                 byte_strobe,
	output pickin_pkg::spi_cmd_e cmd,
	output logic [1:0]           byte_index,
	output logic [7:0]           byte_data
);

	localparam int SYNC = `PICKIN_SYNC_STAGES;

	logic [SYNC-1:0] sck_sync, ss_sync, di_sync;
	logic sck_last, sck_rise, ss_d, di_d;
	logic [2:0] bit_cnt;
	logic [1:0] pay_cnt;
	logic have_cmd;
	logic [6:0] shift;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sck_sync <= '0;
			ss_sync <= '1; // Deselected until the controller pulls the line low.
			di_sync <= '0;
			sck_last <= 1'b0;
			sck_rise <= 1'b0;
			ss_d <= 1'b1;
			di_d <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[SYNC-2:0], spi_sck};
			ss_sync <= {ss_sync[SYNC-2:0], spi_ss_io};
			di_sync <= {di_sync[SYNC-2:0], spi_di};
			sck_last <= sck_sync[SYNC-1];
			sck_rise <= sck_sync[SYNC-1] & ~sck_last;
			ss_d <= ss_sync[SYNC-1]; // Keeps select and data aligned with sck_rise.
			di_d <= di_sync[SYNC-1];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			byte_strobe <= 1'b0;
			cmd <= pickin_pkg::spi_cmd_e'(8'h00);
			byte_index <= 2'd0;
			bit_cnt <= 3'd0;
			pay_cnt <= 2'd0;
			have_cmd <= 1'b0;
		end else begin
			byte_strobe <= 1'b0;
			if (ss_d) begin
				bit_cnt <= 3'd0;
				pay_cnt <= 2'd0;
				have_cmd <= 1'b0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					if (!have_cmd) begin
						cmd <= pickin_pkg::spi_cmd_e'({shift, di_d});
						have_cmd <= 1'b1;
					end else begin
						byte_strobe <= 1'b1;
						byte_index <= pay_cnt;
						if (pay_cnt != 2'd3)
							pay_cnt <= pay_cnt + 2'd1; // Saturates on long frames.
					end
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!ss_d && sck_rise) begin
			shift <= {shift[5:0], di_d}; // MSB first.
			if (bit_cnt == 3'd7)
				byte_data <= {shift, di_d};
		end
	end

endmodule

/* core_config.sv */
module core_config (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 byte_strobe,
	input  pickin_pkg::spi_cmd_e cmd,
	input  logic [1:0]           byte_index,
	input  logic [7:0]           byte_data,
	output logic                 core_reset,
	output logic                 rotate,
	output logic [1:0]           scanlines,
	output logic [7:0]           joystick_0,
	output logic [7:0]           joystick_1
);

	pickin_pkg::status_word_t status;
	logic [1:0] buttons; // Switch bits 3:2 of the byte steer nothing in this core.

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status.raw <= '0;
			buttons <= 2'b00;
			joystick_0 <= 8'h00;
			joystick_1 <= 8'h00;
			core_reset <= 1'b0;
		end else begin
			core_reset <= status.fields.menu_reset | status.fields.reset_trigger | buttons[1];
			if (byte_strobe) begin
				case (cmd)
					pickin_pkg::CMD_STATUS: status.raw[{byte_index, 3'b000} +: 8] <= byte_data;
					pickin_pkg::CMD_BUTTONS: buttons <= byte_data[1:0];
					pickin_pkg::CMD_JOY0: joystick_0 <= byte_data;
					pickin_pkg::CMD_JOY1: joystick_1 <= byte_data;
					default: ;
				endcase
			end
		end
	end

	assign rotate = ~status.fields.rotate_ctrl; // The menu option reads "rotate off" when set.
	assign scanlines = status.fields.scanlines;

endmodule

/* arcade_inputs.sv */
`include "pickin_defs.svh"

module arcade_inputs (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 byte_strobe,
	input  pickin_pkg::spi_cmd_e cmd,
	input  logic [7:0]           byte_data,
	input  logic                 rotate,
	input  logic [7:0]           joystick_0,
	input  logic [7:0]           joystick_1,
	output logic [9:0]           player1,
	output logic [9:0]           player2,
	output logic [8:0]           controls
);

	// Bit positions in the held-key vector.
	localparam int K_UP = 0, K_DOWN = 1, K_LEFT = 2, K_RIGHT = 3;
	localparam int K_CTRL = 4, K_ALT = 5, K_SPACE = 6;
	localparam int K_1 = 7, K_2 = 8, K_5 = 9, K_6 = 10, K_T = 11;
	localparam int K_R = 12, K_F = 13, K_D = 14, K_G = 15, K_A = 16;

	logic [16:0] held;
	logic ext, brk, make, key_strobe;
	logic [3:0] dir1, dir2;

	// Direction nibble is {up, down, left, right}.
	function automatic logic [3:0] turn(input logic [3:0] d, input logic rot);
		if (rot)
			turn = {d[1], d[0], d[2], d[3]};
		else
			turn = d;
	endfunction

	assign key_strobe = byte_strobe && (cmd == pickin_pkg::CMD_KEY);
	assign make = ~brk;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ext <= 1'b0;
			brk <= 1'b0;
			held <= '0;
		end else if (key_strobe) begin
			if (byte_data == `PICKIN_KEY_EXT)
				ext <= 1'b1;
			else if (byte_data == `PICKIN_KEY_BREAK)
				brk <= 1'b1;
			else begin
				ext <= 1'b0; // Prefixes apply to the next code only.
				brk <= 1'b0;
				case (byte_data)
					`PICKIN_KEY_UP: if (ext) held[K_UP] <= make;
					`PICKIN_KEY_DOWN: if (ext) held[K_DOWN] <= make;
					`PICKIN_KEY_LEFT: if (ext) held[K_LEFT] <= make;
					`PICKIN_KEY_RIGHT: if (ext) held[K_RIGHT] <= make;
					`PICKIN_KEY_CTRL: held[K_CTRL] <= make; // Left or right ctrl.
					`PICKIN_KEY_ALT: held[K_ALT] <= make;
					`PICKIN_KEY_SPACE: held[K_SPACE] <= make;
					`PICKIN_KEY_1: held[K_1] <= make;
					`PICKIN_KEY_2: held[K_2] <= make;
					`PICKIN_KEY_5: held[K_5] <= make;
					`PICKIN_KEY_6: held[K_6] <= make;
					`PICKIN_KEY_T: held[K_T] <= make;
					`PICKIN_KEY_R: held[K_R] <= make;
					`PICKIN_KEY_F: held[K_F] <= make;
					`PICKIN_KEY_D: held[K_D] <= make;
					`PICKIN_KEY_G: held[K_G] <= make;
					`PICKIN_KEY_A: held[K_A] <= make;
					default: ;
				endcase
			end
		end
	end

	assign dir1 = joystick_0[3:0] | {held[K_UP], held[K_DOWN], held[K_LEFT], held[K_RIGHT]};
	assign dir2 = joystick_1[3:0] | {held[K_R], held[K_F], held[K_D], held[K_G]};

	assign player1 = {2'b00, joystick_0[7:4] | {1'b0, held[K_SPACE], held[K_ALT], held[K_CTRL]},
		turn(dir1, rotate)};
	assign player2 = {2'b00, joystick_1[7:4] | {3'b000, held[K_A]}, turn(dir2, rotate)};

	// Tilt, coins 4 to 1, then starts 4 to 1.
	assign controls = {held[K_T], 2'b00, held[K_6], held[K_5], 2'b00, held[K_2], held[K_1]};

endmodule

/* sigma_delta_dac.sv */
`include "pickin_defs.svh"

module sigma_delta_dac (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [`PICKIN_AUDIO_BITS-1:0] dac_in,
	output logic                          dac_out
);

	logic [`PICKIN_AUDIO_BITS-1:0] acc;
	logic [`PICKIN_AUDIO_BITS:0] sum;

	assign sum = {1'b0, acc} + {1'b0, dac_in};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			dac_out <= 1'b0;
		end else begin
			acc <= sum[`PICKIN_AUDIO_BITS-1:0];
			dac_out <= sum[`PICKIN_AUDIO_BITS]; // Carry density tracks dac_in.
		end
	end

endmodule

/* video_out.sv */
`include "pickin_defs.svh"

module video_out (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [`PICKIN_COLOR_BITS-1:0] r,
	input  logic [`PICKIN_COLOR_BITS-1:0] g,
	input  logic [`PICKIN_COLOR_BITS-2:0] b,
	input  logic                          hblank,
	input  logic                          vblank,
	input  logic                          hs,
	input  logic                          vs,
	input  logic [1:0]                    scanlines,
	output logic [5:0]                    vga_r,
	output logic [5:0]                    vga_g,
	output logic [5:0]                    vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs
);

	logic [5:0] r6, g6, b6;
	logic blank, odd_line, hs_last, vs_last;

	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] level);
		logic [7:0] three_q;
		three_q = ({2'b00, c} + {1'b0, c, 1'b0}) >> 2;
		case (level)
			2'd1: dim = c - (c >> 2);
			2'd2: dim = c - (c >> 1);
			2'd3: dim = c - three_q[5:0];
			default: dim = c;
		endcase
	endfunction

	assign blank = hblank | vblank;
	assign r6 = {r, r};
	assign g6 = {g, g};
	assign b6 = {b, 1'b0, b, 1'b0}; // Blue is padded to 3 bits first.

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hs_last <= 1'b0;
			vs_last <= 1'b0;
			odd_line <= 1'b0;
			vga_r <= 6'd0;
			vga_g <= 6'd0;
			vga_b <= 6'd0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			hs_last <= hs;
			vs_last <= vs;
			if (vs_last && !vs)
				odd_line <= 1'b0; // Each frame starts on an even line.
			else if (hs_last && !hs)
				odd_line <= ~odd_line;
			vga_hs <= hs;
			vga_vs <= vs;
			if (blank) begin
				vga_r <= 6'd0;
				vga_g <= 6'd0;
				vga_b <= 6'd0;
			end else if (odd_line) begin
				vga_r <= dim(r6, scanlines);
				vga_g <= dim(g6, scanlines);
				vga_b <= dim(b6, scanlines);
			end else begin
				vga_r <= r6;
				vga_g <= g6;
				vga_b <= b6;
			end
		end
	end

endmodule

/* pickin_mist.sv */
`include "pickin_defs.svh"

module pickin_mist (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          spi_sck,
	input  logic                          spi_ss_io,
	input  logic                          spi_di,
	input  logic [`PICKIN_COLOR_BITS-1:0] game_r,
	input  logic [`PICKIN_COLOR_BITS-1:0] game_g,
	input  logic [`PICKIN_COLOR_BITS-2:0] game_b,
	input  logic                          game_hblank,
	input  logic                          game_vblank,
	input  logic                          game_hs,
	input  logic                          game_vs,
	input  logic [`PICKIN_AUDIO_BITS-1:0] game_audio,
	output logic [5:0]                    vga_r,
	output logic [5:0]                    vga_g,
	output logic [5:0]                    vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs,
	output logic                          audio_l,
	output logic                          audio_r,
	output logic                          core_reset,
	output logic [9:0]                    player1,
	output logic [9:0]                    player2,
	output logic [8:0]                    controls
);

	logic byte_strobe;
	pickin_pkg::spi_cmd_e cmd;
	logic [1:0] byte_index;
	logic [7:0] byte_data;
	logic rotate;
	logic [1:0] scanlines;
	logic [7:0] joystick_0, joystick_1;

	assign audio_r = audio_l; // Mono game, both channels carry the same stream.

	spi_cmd_rx spi_cmd_rx_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.spi_sck     (spi_sck),
		.spi_ss_io   (spi_ss_io),
		.spi_di      (spi_di),
		.byte_strobe (byte_strobe),
		.cmd         (cmd),
		.byte_index  (byte_index),
		.byte_data   (byte_data)
	);

	core_config core_config_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.byte_strobe (byte_strobe),
		.cmd         (cmd),
		.byte_index  (byte_index),
		.byte_data   (byte_data),
		.core_reset  (core_reset),
		.rotate      (rotate),
		.scanlines   (scanlines),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1)
	);

	arcade_inputs arcade_inputs_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.byte_strobe (byte_strobe),
		.cmd         (cmd),
		.byte_data   (byte_data),
		.rotate      (rotate),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.player1     (player1),
		.player2     (player2),
		.controls    (controls)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dac_in  (game_audio),
		.dac_out (audio_l)
	);

	video_out video_out_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.r         (game_r),
		.g         (game_g),
		.b         (game_b),
		.hblank    (game_hblank),
		.vblank    (game_vblank),
		.hs        (game_hs),
		.vs        (game_vs),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

endmodule

/* pickin_properties.sv */
module pickin_properties (
	input logic                 clk_sys,
	input logic                 rst_n,
	input logic                 spi_ss_io,
	input logic                 byte_strobe,
	input pickin_pkg::spi_cmd_e cmd,
	input logic                 game_hblank,
	input logic                 game_vblank,
	input logic [5:0]           vga_r,
	input logic [5:0]           vga_g,
	input logic [5:0]           vga_b,
	input logic                 audio_l,
	input logic                 audio_r,
	input logic                 core_reset
);

	logic config_seen;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			config_seen <= 1'b0;
		else if (byte_strobe &&
			(cmd == pickin_pkg::CMD_STATUS || cmd == pickin_pkg::CMD_BUTTONS))
			config_seen <= 1'b1;
	end

	audio_mirror: assert property (@(posedge clk_sys) disable iff (!rst_n)
		audio_r == audio_l)
		else $error("audio_r differs from audio_l");

	blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(game_hblank || game_vblank) |=> (vga_r == 6'd0 && vga_g == 6'd0 && vga_b == 6'd0))
		else $error("Colour output not black one cycle after blanking");

	strobe_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		spi_ss_io |-> !byte_strobe)
		else $error("byte_strobe high while spi_ss_io is high");

	// Only a status or buttons byte can raise core_reset.
	quiet_reset: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!config_seen |-> !core_reset)
		else $error("core_reset high before any status or buttons frame");

endmodule

bind pickin_mist pickin_properties pickin_properties_i (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.spi_ss_io   (spi_ss_io),
	.byte_strobe (byte_strobe),
	.cmd         (cmd),
	.game_hblank (game_hblank),
	.game_vblank (game_vblank),
	.vga_r       (vga_r),
	.vga_g       (vga_g),
	.vga_b       (vga_b),
	.audio_l     (audio_l),
	.audio_r     (audio_r),
	.core_reset  (core_reset)
);

/* tb_checker.sv */
module tb_checker (
	input  logic        clk_sys,
	input  logic        req,
	input  logic [87:0] rec,
	input  logic        core_reset,
	input  logic [9:0]  player1,
	input  logic [9:0]  player2,
	input  logic [8:0]  controls,
	input  logic [5:0]  vga_r,
	input  logic [5:0]  vga_g,
	input  logic [5:0]  vga_b,
	input  logic        vga_hs,
	input  logic        vga_vs,
	input  logic        audio_l,
	input  logic        audio_r,
	output int          checks,
	output int          errors
);

	task automatic check_value(input string name, input logic [11:0] got,
		input logic [11:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// A first-order modulator may land one count either side of the input value.
	task automatic check_count(input string name, input int got, input int exp);
		if (got > exp + 1 || got < exp - 1) begin
			errors++;
			$display("[FAIL] %0t %s high count got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	initial begin
		logic [87:0] r;
		int highs_l;
		int highs_r;
		checks = 0;
		errors = 0;
		forever begin
			@(posedge clk_sys);
			if (req) begin
				r = rec;
				case (r[87:84])
					4'h1: begin
						repeat (8) @(posedge clk_sys); // Registers settle within 6 cycles.
						@(negedge clk_sys);
						check_value("core_reset", {11'd0, core_reset}, {8'd0, r[39:36]});
						check_value("player1", {2'd0, player1}, r[35:24]);
						check_value("player2", {2'd0, player2}, r[23:12]);
						check_value("controls", {3'd0, controls}, r[11:0]);
					end
					4'h2: begin
						@(negedge clk_sys);
						check_value("vga_r", {6'd0, vga_r}, {4'd0, r[31:24]});
						check_value("vga_g", {6'd0, vga_g}, {4'd0, r[23:16]});
						check_value("vga_b", {6'd0, vga_b}, {4'd0, r[15:8]});
						check_value("vga_hs", {11'd0, vga_hs}, {8'd0, r[7:4]});
						check_value("vga_vs", {11'd0, vga_vs}, {8'd0, r[3:0]});
					end
					4'h3: begin
						highs_l = 0;
						highs_r = 0;
						repeat (8192) begin
							@(negedge clk_sys);
							if (audio_l)
								highs_l++;
							if (audio_r)
								highs_r++;
						end
						check_count("audio_l", highs_l, int'(r[55:40]));
						check_count("audio_r", highs_r, int'(r[55:40]));
					end
					default: begin
						errors++;
						$display("Pattern record of unknown kind %h was skipped", r[87:84]);
					end
				endcase
				checks++;
			end
		end
	end

endmodule

/* tb_pickin_mist.sv */
`include "pickin_defs.svh"

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

module tb_pickin_mist;

	logic clk_sys, rst_n;
	logic spi_sck, spi_ss_io, spi_di;
	logic [`PICKIN_COLOR_BITS-1:0] game_r, game_g;
	logic [`PICKIN_COLOR_BITS-2:0] game_b;
	logic game_hblank, game_vblank, game_hs, game_vs;
	logic [`PICKIN_AUDIO_BITS-1:0] game_audio;
	logic [5:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_l, audio_r, core_reset;
	logic [9:0] player1, player2;
	logic [8:0] controls;
	logic req;
	logic [87:0] rec;
	logic [87:0] patterns [0:63];
	int checks, errors, n_records, n_audio, limit, cycles;

	tb_clock_gen clock_i (.clk_sys(clk_sys), .rst_n(rst_n));

	pickin_mist pickin_mist_i (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.spi_sck(spi_sck), .spi_ss_io(spi_ss_io), .spi_di(spi_di),
		.game_r(game_r), .game_g(game_g), .game_b(game_b),
		.game_hblank(game_hblank), .game_vblank(game_vblank),
		.game_hs(game_hs), .game_vs(game_vs), .game_audio(game_audio),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.audio_l(audio_l), .audio_r(audio_r), .core_reset(core_reset),
		.player1(player1), .player2(player2), .controls(controls)
	);

	tb_checker checker_i (
		.clk_sys(clk_sys), .req(req), .rec(rec),
		.core_reset(core_reset), .player1(player1), .player2(player2), .controls(controls),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.audio_l(audio_l), .audio_r(audio_r), .checks(checks), .errors(errors)
	);

	// SPI mode 0 at a quarter of clk_sys, command byte first, MSB first.
	task automatic send_frame(input logic [3:0] n, input logic [39:0] bytes);
		logic [39:0] sh;
		int b;
		sh = bytes;
		@(posedge clk_sys);
		spi_ss_io <= 1'b0;
		for (b = 0; b < 8 * int'(n); b++) begin
			@(posedge clk_sys);
			spi_sck <= 1'b0;
			spi_di <= sh[39];
			sh = sh << 1;
			repeat (2) @(posedge clk_sys);
			spi_sck <= 1'b1;
			@(posedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
		spi_sck <= 1'b0;
		repeat (6) @(posedge clk_sys); // The last strobe is gone before select rises.
		spi_ss_io <= 1'b1;
	endtask

	task automatic apply_record(input logic [87:0] r);
		case (r[87:84])
			4'h1: send_frame(r[83:80], r[79:40]);
			4'h2: begin
				@(posedge clk_sys);
				game_r <= r[70:68];
				game_g <= r[66:64];
				game_b <= r[61:60];
				game_hblank <= r[56];
				game_vblank <= r[52];
				game_hs <= r[48];
				game_vs <= r[44];
			end
			4'h3: begin
				@(posedge clk_sys);
				game_audio <= r[52:40];
			end
			default: @(posedge clk_sys);
		endcase
		rec <= r;
		req <= 1'b1;
		@(posedge clk_sys);
		req <= 1'b0;
	endtask

	initial begin
		int i;
		spi_sck = 1'b0;
		spi_ss_io = 1'b1;
		spi_di = 1'b0;
		game_r = '0;
		game_g = '0;
		game_b = '0;
		game_hblank = 1'b0;
		game_vblank = 1'b0;
		game_hs = 1'b0;
		game_vs = 1'b0;
		game_audio = '0;
		req = 1'b0;
		rec = '0;
		for (i = 0; i < 64; i++)
			patterns[i] = '0;
		$readmemh("pickin_patterns.hex", patterns);
		n_records = 0;
		n_audio = 0;
		while (n_records < 64 && patterns[n_records][87:84] != 4'h0) begin
			if (patterns[n_records][87:84] == 4'h3)
				n_audio++;
			n_records++;
		end
		limit = n_records * 300 + n_audio * 8192 + 20000; // Each audio window is 8192 cycles.
		@(posedge rst_n);
		repeat (2) @(posedge clk_sys);
		for (i = 0; i < n_records; i++) begin
			apply_record(patterns[i]);
			while (checks < i + 1)
				@(posedge clk_sys);
		end
		$display("Records %0d, checks done %0d, errors %0d", n_records, checks, errors);
		if (errors == 0 && n_records > 0 && checks == n_records)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d checks done", limit, checks);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* pickin_patterns.hex */
// SPI frame: 1_count_bytes (command first)_core_reset_player1_player2_controls
// Video: 2_0_00_{r g b hblank vblank hs vs 0}_00_{vga_r vga_g vga_b hs vs}; audio: 3_0_value_0
1_5_1e40000000_1_000_000_000
1_5_1e01000000_1_000_000_000
1_5_1e04000000_0_000_000_000
1_2_0102000000_1_000_000_000
1_2_0100000000_0_000_000_000
1_2_0219000000_0_019_000_000
1_5_1e00000000_0_015_000_000
1_2_032a000000_0_015_029_000
1_5_1e14000000_0_019_02a_000
1_2_04e0000000_0_019_02a_000
1_2_046b000000_0_01b_02a_000
1_2_0429000000_0_05b_02a_000
1_2_042e000000_0_05b_02a_010
1_2_041c000000_0_05b_03a_010
1_2_04f0000000_0_05b_03a_010
1_2_0429000000_0_01b_03a_010
2_0_00_73210100_00_00000010
2_0_00_53200000_00_2d1b2400
2_0_00_53200000_00_170e1200
2_0_00_77301110_00_00000011
2_0_00_77300000_00_20201b00
3_0_0000000000_0000000000
3_0_0000000a55_0000000000
3_0_0000001fff_0000000000

/* project.f */
+incdir+.
pickin_pkg.sv
spi_cmd_rx.sv
core_config.sv
arcade_inputs.sv
sigma_delta_dac.sv
video_out.sv
pickin_mist.sv
pickin_properties.sv
tb_checker.sv
tb_pickin_mist.sv

/* Makefile */
SIM := obj_dir/Vtb_pickin_mist

all: run

$(SIM): project.f pickin_defs.svh $(shell grep '\.sv$$' project.f)
	verilator --binary --timing --assert -f project.f --top-module tb_pickin_mist -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
